//--- verilog/can_lite_settings.svh
// Register map and field widths are fixed at compile time and must match the host driver
`ifndef CAN_LITE_SETTINGS_SVH
`define CAN_LITE_SETTINGS_SVH

// Host register addresses
`define CAN_ADDR_MODE       8'd0
`define CAN_ADDR_CMD        8'd1
`define CAN_ADDR_STATUS     8'd2
`define CAN_ADDR_IRQ        8'd3
`define CAN_ADDR_BTR0       8'd6
`define CAN_ADDR_BTR1       8'd7
`define CAN_ADDR_TX_DATA    8'd10
`define CAN_ADDR_RX_DATA    8'd20

// Bus data, bus address and payload byte
`define CAN_DATA_W          8

// Bus timing fields as laid out in BTR0 and BTR1
`define CAN_BRP_W           6
`define CAN_TSEG1_W         4
`define CAN_TSEG2_W         3

// Holds the longest bit of 3 + 15 + 7 quanta
`define CAN_QUANTA_W        5

// Idle bus level
`define CAN_RECESSIVE       1'b1

// Node comes up in reset mode
`define CAN_MODE_RST        1'b1

`endif

//--- verilog/can_lite_pkg.sv
// Shared node types; field widths come from the settings header and BTR bit order is fixed
`include "can_lite_settings.svh"

package can_lite_pkg;

    // Host bus request with chip select already active high
    typedef struct packed {
        logic                   cs;
        logic                   wr;
        logic                   rd;
        logic [`CAN_DATA_W-1:0] addr;
        logic [`CAN_DATA_W-1:0] wr_dat;
    } host_req_t;

    typedef struct packed {
        logic [`CAN_BRP_W-1:0]   brp;
        logic [`CAN_TSEG1_W-1:0] tseg1;
        logic [`CAN_TSEG2_W-1:0] tseg2;
    } timing_cfg_t;

    // BTR0 layout with the jump width bits unused
    typedef struct packed {
        logic [1:0]            rsvd;
        logic [`CAN_BRP_W-1:0] brp;
    } btr0_view_t;

    // BTR1 layout with the triple sampling bit unused
    typedef struct packed {
        logic                    rsvd;
        logic [`CAN_TSEG2_W-1:0] tseg2;
        logic [`CAN_TSEG1_W-1:0] tseg1;
    } btr1_view_t;

    typedef union packed {
        btr0_view_t btr0;
        btr1_view_t btr1;
    } btr_word_u;

    // Single-cycle strobes from the bit timer
    typedef struct packed {
        logic tx_point;
        logic sample_point;
    } bit_events_t;

    typedef struct packed {
        logic                   tx_busy;
        logic                   rx_busy;
        logic                   tx_done;
        logic                   rx_done;
        logic [`CAN_DATA_W-1:0] rx_byte;
    } link_status_t;

endpackage

//--- verilog/can_host_regs.sv
// Timing registers accept writes in any mode; change them only while reset mode is set
`timescale 1ns/1ps
`include "can_lite_settings.svh"

module can_host_regs
    import can_lite_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  host_req_t              req,
    input  link_status_t           link,
    output logic [`CAN_DATA_W-1:0] rd_dat,
    output logic                   irq_on,
    output timing_cfg_t            cfg,
    output logic                   reset_mode,
    output logic                   tx_start,
    output logic [`CAN_DATA_W-1:0] tx_byte
);

    logic       wr_en;
    logic       rd_en;
    logic       rd_irq;
    btr_word_u  btr0_q;
    btr_word_u  btr1_q;
    logic [1:0] irq_q;      // {rx_done, tx_done}

    assign wr_en  = req.cs & req.wr;
    assign rd_en  = req.cs & req.rd;
    assign rd_irq = rd_en & (req.addr == `CAN_ADDR_IRQ);

    // Mode and bus timing registers
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            reset_mode <= `CAN_MODE_RST;
            btr0_q     <= '0;
            btr1_q     <= '0;
        end
        else if (wr_en)
        begin
            case (req.addr)
                `CAN_ADDR_MODE: reset_mode <= req.wr_dat[0];
                `CAN_ADDR_BTR0: btr0_q     <= req.wr_dat;
                `CAN_ADDR_BTR1: btr1_q     <= req.wr_dat;
                default: ;
            endcase
        end
    end

    // Same register word seen through its two field layouts
    assign cfg.brp   = btr0_q.btr0.brp;
    assign cfg.tseg1 = btr1_q.btr1.tseg1;
    assign cfg.tseg2 = btr1_q.btr1.tseg2;

    // Byte for the next transmission
    always_ff @(posedge clk)
    begin
        if (wr_en && (req.addr == `CAN_ADDR_TX_DATA))
            tx_byte <= req.wr_dat;
    end

    // One pulse per command write with bit 0 set
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            tx_start <= 1'b0;
        else
            tx_start <= wr_en && (req.addr == `CAN_ADDR_CMD) && req.wr_dat[0];
    end

    // Sticky done flags
    // A done pulse on the clearing read edge still sets its bit
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            irq_q <= 2'b00;
        else
            irq_q <= (rd_irq ? 2'b00 : irq_q) | {link.rx_done, link.tx_done};
    end

    assign irq_on = |irq_q;

    // Read mux captured on the read strobe and held until the next read
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            rd_dat <= '0;
        else if (rd_en)
        begin
            case (req.addr)
                `CAN_ADDR_MODE:    rd_dat <= {{(`CAN_DATA_W-1){1'b0}}, reset_mode};
                `CAN_ADDR_STATUS:  rd_dat <= {{(`CAN_DATA_W-2){1'b0}}, link.rx_busy, link.tx_busy};
                `CAN_ADDR_IRQ:     rd_dat <= {{(`CAN_DATA_W-2){1'b0}}, irq_q};
                `CAN_ADDR_BTR0:    rd_dat <= btr0_q;
                `CAN_ADDR_BTR1:    rd_dat <= btr1_q;
                `CAN_ADDR_RX_DATA: rd_dat <= link.rx_byte;
                default:           rd_dat <= '0;
            endcase
        end
    end

endmodule

//--- verilog/can_bit_timing.sv
// Free-running bit timer with no resynchronization; timing is meant to change only in reset mode
`timescale 1ns/1ps
`include "can_lite_settings.svh"

module can_bit_timing
    import can_lite_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  timing_cfg_t cfg,
    input  logic        reset_mode,
    output bit_events_t ev
);

    logic [`CAN_BRP_W:0]      presc_cnt;
    logic [`CAN_BRP_W:0]      presc_last;
    logic                     quantum_end;
    logic [`CAN_QUANTA_W-1:0] quanta_cnt;
    logic [`CAN_QUANTA_W-1:0] bit_last;
    logic [`CAN_QUANTA_W-1:0] sample_q;

    // Quantum of 2*(brp+1) clocks
    assign presc_last  = {cfg.brp, 1'b1};
    assign quantum_end = (presc_cnt == presc_last);

    // Sync quantum, then tseg1+1 and tseg2+1 quanta
    assign bit_last = `CAN_QUANTA_W'(cfg.tseg1) + `CAN_QUANTA_W'(cfg.tseg2) + `CAN_QUANTA_W'(2);
    assign sample_q = `CAN_QUANTA_W'(cfg.tseg1) + `CAN_QUANTA_W'(2);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            presc_cnt <= '0;
        else if (reset_mode || quantum_end)
            presc_cnt <= '0;
        else
            presc_cnt <= presc_cnt + 1'b1;
    end

    // Quantum index within the bit
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            quanta_cnt <= '0;
        else if (reset_mode)
            quanta_cnt <= '0;
        else if (quantum_end)
        begin
            if (quanta_cnt >= bit_last)
                quanta_cnt <= '0;
            else
                quanta_cnt <= quanta_cnt + 1'b1;
        end
    end

    // Both events fall on the first clock of their quantum
    assign ev.tx_point     = !reset_mode && (presc_cnt == '0) && (quanta_cnt == '0);
    assign ev.sample_point = !reset_mode && (presc_cnt == '0) && (quanta_cnt == sample_q);

endmodule

//--- verilog/can_bit_shifter.sv
// One start bit and one byte MSB first each way; no framing, stuffing or error handling
`timescale 1ns/1ps
`include "can_lite_settings.svh"

module can_bit_shifter
    import can_lite_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   reset_mode,
    input  bit_events_t            ev,
    input  logic                   tx_start,
    input  logic [`CAN_DATA_W-1:0] tx_byte,
    input  logic                   rx,
    output logic                   tx,
    output link_status_t           link
);

    logic                   rx_meta;
    logic                   rx_sync;
    logic [`CAN_DATA_W:0]   tx_shift;
    logic [3:0]             tx_cnt;
    logic                   tx_busy;
    logic                   tx_done;
    logic [`CAN_DATA_W-2:0] rx_shift;
    logic [2:0]             rx_cnt;
    logic                   rx_busy;
    logic                   rx_done;
    logic [`CAN_DATA_W-1:0] rx_byte;

    // Two-flop synchronizer idling recessive
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            rx_meta <= `CAN_RECESSIVE;
            rx_sync <= `CAN_RECESSIVE;
        end
        else
        begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    // Transmit control sends the start bit and 8 data bits then idles
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            tx      <= `CAN_RECESSIVE;
            tx_busy <= 1'b0;
            tx_cnt  <= '0;
            tx_done <= 1'b0;
        end
        else
        begin
            tx_done <= 1'b0;
            if (reset_mode)
            begin
                tx      <= `CAN_RECESSIVE;
                tx_busy <= 1'b0;
            end
            else if (!tx_busy)
            begin
                if (tx_start)
                begin
                    tx_busy <= 1'b1;
                    tx_cnt  <= '0;
                end
            end
            else if (ev.tx_point)
            begin
                // All 9 bits out
                if (tx_cnt == 4'd9)
                begin
                    tx      <= `CAN_RECESSIVE;
                    tx_busy <= 1'b0;
                    tx_done <= 1'b1;
                end
                else
                begin
                    tx     <= tx_shift[`CAN_DATA_W];
                    tx_cnt <= tx_cnt + 4'd1;
                end
            end
        end
    end

    // Dominant start bit in front of the byte
    always_ff @(posedge clk)
    begin
        if (!tx_busy && tx_start)
            tx_shift <= {~`CAN_RECESSIVE, tx_byte};
        else if (tx_busy && ev.tx_point)
            tx_shift <= {tx_shift[`CAN_DATA_W-1:0], `CAN_RECESSIVE};
    end

    // Receive control
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            rx_busy <= 1'b0;
            rx_cnt  <= '0;
            rx_done <= 1'b0;
            rx_byte <= '0;
        end
        else
        begin
            rx_done <= 1'b0;
            if (reset_mode)
                rx_busy <= 1'b0;
            else if (ev.sample_point)
            begin
                if (!rx_busy)
                begin
                    // Dominant sample while idle is the start bit
                    if (rx_sync != `CAN_RECESSIVE)
                    begin
                        rx_busy <= 1'b1;
                        rx_cnt  <= '0;
                    end
                end
                else if (rx_cnt == 3'd7)
                begin
                    rx_busy <= 1'b0;
                    rx_done <= 1'b1;
                    rx_byte <= {rx_shift, rx_sync};
                end
                else
                    rx_cnt <= rx_cnt + 3'd1;
            end
        end
    end

    // Holds the first seven data bits while the eighth goes straight into rx_byte
    always_ff @(posedge clk)
    begin
        if (rx_busy && ev.sample_point)
            rx_shift <= {rx_shift[`CAN_DATA_W-3:0], rx_sync};
    end

    assign link.tx_busy = tx_busy;
    assign link.rx_busy = rx_busy;
    assign link.tx_done = tx_done;
    assign link.rx_done = rx_done;
    assign link.rx_byte = rx_byte;

endmodule

//--- verilog/can_lite_top.sv
// Local bus pins as on the full controller, but only the reduced register map is decoded
`timescale 1ns/1ps
`include "can_lite_settings.svh"

module can_lite_top
    import can_lite_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   lbe_cs_n,
    input  logic                   lbe_wr_en,
    input  logic                   lbe_rd_en,
    input  logic [`CAN_DATA_W-1:0] lbe_addr,
    input  logic [`CAN_DATA_W-1:0] lbe_wr_dat,
    output logic [`CAN_DATA_W-1:0] lbe_rd_dat,
    output logic                   irq_on,
    input  logic                   rx,
    output logic                   tx
);

    host_req_t              req;
    timing_cfg_t            cfg;
    logic                   reset_mode;
    logic                   tx_start;
    logic [`CAN_DATA_W-1:0] tx_byte;
    bit_events_t            ev;
    link_status_t           link;

    // Chip select is active low on the pin
    assign req.cs     = ~lbe_cs_n;
    assign req.wr     = lbe_wr_en;
    assign req.rd     = lbe_rd_en;
    assign req.addr   = lbe_addr;
    assign req.wr_dat = lbe_wr_dat;

    can_host_regs u_can_host_regs (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .link       (link),
        .rd_dat     (lbe_rd_dat),
        .irq_on     (irq_on),
        .cfg        (cfg),
        .reset_mode (reset_mode),
        .tx_start   (tx_start),
        .tx_byte    (tx_byte)
    );

    can_bit_timing u_can_bit_timing (
        .clk        (clk),
        .rst        (rst),
        .cfg        (cfg),
        .reset_mode (reset_mode),
        .ev         (ev)
    );

    can_bit_shifter u_can_bit_shifter (
        .clk        (clk),
        .rst        (rst),
        .reset_mode (reset_mode),
        .ev         (ev),
        .tx_start   (tx_start),
        .tx_byte    (tx_byte),
        .rx         (rx),
        .tx         (tx),
        .link       (link)
    );

endmodule

//--- verification/can_lite_checker.sv
// Assumes tx idles high and the testbench announces each loopback frame before tx falls
`timescale 1ns/1ps

module can_lite_checker (
    input  logic       clk,
    input  logic       rst,
    input  logic       tx,
    input  logic       irq_on,
    input  logic [7:0] rd_dat,
    output int         error_count
);

    string      test_name = "none";
    int         test_errors = 0;
    int         tests_done = 0;
    int         bit_clks = 1;
    logic       armed = 1'b0;
    logic [8:0] exp_frame = '0;

    initial
        error_count = 0;

    task automatic note_error(input string msg);
        $display("%s", msg);
        test_errors++;
        error_count++;
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
        armed       = 1'b0;
    endtask

    // Start bit, then the byte MSB first
    task automatic expect_frame(input logic [7:0] data, input int clks);
        exp_frame = {1'b0, data};
        bit_clks  = clks;
        armed     = 1'b1;
    endtask

    task automatic check_read(input string field, input logic [7:0] exp);
        if (rd_dat !== exp)
            note_error($sformatf("MISMATCH %s %s expected %02h actual %02h",
                                 test_name, field, exp, rd_dat));
    endtask

    task automatic check_irq(input logic exp);
        if (irq_on !== exp)
            note_error($sformatf("MISMATCH %s irq_on expected %0b actual %0b",
                                 test_name, exp, irq_on));
    endtask

    // Every falling clock edge of the frame is compared, so a late or early edge shows up
    task automatic watch_frame();
        logic [8:0] seen;
        logic       exp_bit;
        int         idx;
        int         bad_samples;
        armed       = 1'b0;
        seen        = '1;
        bad_samples = 0;
        for (int n = 0; n <= 9 * bit_clks; n++)
        begin
            @(negedge clk);
            idx     = n / bit_clks;
            exp_bit = (idx < 9) ? exp_frame[8 - idx] : 1'b1;
            // Mid-bit value
            if ((idx < 9) && (n % bit_clks == bit_clks / 2))
                seen[8 - idx] = tx;
            if (tx !== exp_bit)
                bad_samples++;
        end
        if (seen !== exp_frame)
            note_error($sformatf("MISMATCH %s tx frame expected %03h actual %03h",
                                 test_name, exp_frame, seen));
        else if (bad_samples != 0)
            note_error($sformatf("Bit edges on tx are misplaced in test %s, %0d bad samples",
                                 test_name, bad_samples));
    endtask

    always @(negedge tx)
    begin
        if (rst === 1'b0)
        begin
            if (!armed)
                note_error($sformatf("Unexpected tx activity during test %s", test_name));
            else
                watch_frame();
        end
    end

    task automatic end_test();
        tests_done++;
        if (test_errors == 0)
            $display("PASS %s", test_name);
        else
            $display("FAIL %s with %0d errors", test_name, test_errors);
    endtask

    task automatic report_summary();
        $display("Tests run %0d, errors %0d", tests_done, error_count);
    endtask

endmodule

//--- verification/can_lite_tb.sv
// Runs the node at a 100 ns clock; external rx bits are aligned to the clock, never to the bit timer
`timescale 1ns/1ps
`include "can_lite_settings.svh"

module can_lite_tb;

    localparam int         CLK_NS     = 100;
    localparam int         NUM_TESTS  = 6;
    localparam logic [1:0] MODE_LOOP  = 2'd0;
    localparam logic [1:0] MODE_EXT   = 2'd1;
    localparam logic [1:0] MODE_BLOCK = 2'd2;

    typedef struct packed {
        logic [5:0] brp;
        logic [3:0] tseg1;
        logic [2:0] tseg2;
        logic [1:0] mode;
        logic       use_lfsr;
        logic [7:0] data;
    } test_vec_t;

    logic       clk;
    logic       rst;
    logic       lbe_cs_n;
    logic       lbe_wr_en;
    logic       lbe_rd_en;
    logic [7:0] lbe_addr;
    logic [7:0] lbe_wr_dat;
    logic [7:0] lbe_rd_dat;
    logic       irq_on;
    logic       tx;
    wire        rx;
    logic       tx_loop = 1'b1;
    logic       rx_drv = 1'b1;
    logic       loopback = 1'b0;
    logic [31:0] lfsr;
    longint     limit_ns = 0;
    int         errors;
    test_vec_t  vectors [NUM_TESTS];
    string      names [NUM_TESTS];

    initial
        clk = 1'b0;
    always #(CLK_NS / 2) clk = ~clk;

    // Loopback path changes only on falling edges like every other input
    always @(negedge clk)
        tx_loop <= tx;
    assign rx = loopback ? tx_loop : rx_drv;

    can_lite_top u_can_lite_top (
        .clk        (clk),
        .rst        (rst),
        .lbe_cs_n   (lbe_cs_n),
        .lbe_wr_en  (lbe_wr_en),
        .lbe_rd_en  (lbe_rd_en),
        .lbe_addr   (lbe_addr),
        .lbe_wr_dat (lbe_wr_dat),
        .lbe_rd_dat (lbe_rd_dat),
        .irq_on     (irq_on),
        .rx         (rx),
        .tx         (tx)
    );

    can_lite_checker u_checker (
        .clk         (clk),
        .rst         (rst),
        .tx          (tx),
        .irq_on      (irq_on),
        .rd_dat      (lbe_rd_dat),
        .error_count (errors)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic random_byte(output logic [7:0] b);
        b = '0;
        for (int i = 0; i < 8; i++)
        begin
            lfsr = lfsr_step(lfsr);
            b    = {b[6:0], lfsr[0]};
        end
    endtask

    // Clocks per bit: 2*(brp+1) per quantum, 3+tseg1+tseg2 quanta
    function automatic int bit_length(input test_vec_t v);
        return 2 * (v.brp + 1) * (3 + v.tseg1 + v.tseg2);
    endfunction

    task automatic bus_write(input logic [7:0] addr, input logic [7:0] data);
        @(negedge clk);
        lbe_cs_n   = 1'b0;
        lbe_wr_en  = 1'b1;
        lbe_addr   = addr;
        lbe_wr_dat = data;
        @(negedge clk);
        lbe_cs_n  = 1'b1;
        lbe_wr_en = 1'b0;
    endtask

    // Returns once the read data is valid
    task automatic bus_read(input logic [7:0] addr);
        @(negedge clk);
        lbe_cs_n  = 1'b0;
        lbe_rd_en = 1'b1;
        lbe_addr  = addr;
        @(negedge clk);
        lbe_cs_n  = 1'b1;
        lbe_rd_en = 1'b0;
    endtask

    task automatic send_rx_byte(input logic [7:0] data, input int blen);
        logic [8:0] frame;
        frame = {1'b0, data};
        for (int k = 8; k >= 0; k--)
        begin
            @(negedge clk);
            rx_drv = frame[k];
            repeat (blen - 1) @(negedge clk);
        end
        @(negedge clk);
        rx_drv = 1'b1;
    endtask

    initial
    begin
        wait (limit_ns > 0);
        #(limit_ns);
        $display("Timeout, the tests did not finish within %0d ns", limit_ns);
        $display("Test failed");
        $finish;
    end

    initial
    begin
        test_vec_t  t;
        int         blen;
        logic [7:0] data;
        logic [7:0] exp_irq;
        longint     total;
        // Fields: brp, tseg1, tseg2, mode, use_lfsr, data
        vectors[0] = {6'd0, 4'd2, 3'd1, MODE_LOOP, 1'b0, 8'hA5};
        vectors[1] = {6'd1, 4'd5, 3'd2, MODE_LOOP, 1'b1, 8'h00};
        vectors[2] = {6'd0, 4'd3, 3'd2, MODE_EXT, 1'b0, 8'h3C};
        vectors[3] = {6'd2, 4'd4, 3'd3, MODE_EXT, 1'b1, 8'h00};
        vectors[4] = {6'd0, 4'd2, 3'd1, MODE_BLOCK, 1'b0, 8'h5A};
        vectors[5] = {6'd3, 4'd7, 3'd4, MODE_LOOP, 1'b0, 8'h81};
        names[0] = "loop_fast";
        names[1] = "loop_random";
        names[2] = "ext_rx";
        names[3] = "ext_rx_random";
        names[4] = "cmd_in_reset_mode";
        names[5] = "loop_slow";
        lfsr       = 32'ha8cf_5cb5;
        rst        = 1'b1;
        lbe_cs_n   = 1'b1;
        lbe_wr_en  = 1'b0;
        lbe_rd_en  = 1'b0;
        lbe_addr   = '0;
        lbe_wr_dat = '0;
        // Frame of 10 bits plus slack for bus access and bit phase, per entry
        total = 200;
        for (int i = 0; i < NUM_TESTS; i++)
            total += 12 * bit_length(vectors[i]) + 150;
        limit_ns = total * CLK_NS;
        repeat (2) @(negedge clk);
        rst = 1'b0;

        u_checker.start_test("after_reset");
        u_checker.check_irq(1'b0);
        bus_read(`CAN_ADDR_STATUS);
        u_checker.check_read("status", 8'h00);
        u_checker.end_test();

        for (int i = 0; i < NUM_TESTS; i++)
        begin
            t    = vectors[i];
            blen = bit_length(t);
            data = t.data;
            if (t.use_lfsr)
                random_byte(data);
            u_checker.start_test(names[i]);
            bus_write(`CAN_ADDR_MODE, 8'h01);
            loopback = (t.mode == MODE_LOOP);
            bus_write(`CAN_ADDR_BTR0, {2'b00, t.brp});
            bus_write(`CAN_ADDR_BTR1, {1'b0, t.tseg2, t.tseg1});
            bus_read(`CAN_ADDR_BTR0);
            u_checker.check_read("btr0", {2'b00, t.brp});
            bus_read(`CAN_ADDR_BTR1);
            u_checker.check_read("btr1", {1'b0, t.tseg2, t.tseg1});
            if (t.mode == MODE_BLOCK)
            begin
                bus_write(`CAN_ADDR_TX_DATA, data);
                bus_write(`CAN_ADDR_CMD, 8'h01);
            end
            bus_write(`CAN_ADDR_MODE, 8'h00);

            case (t.mode)
                MODE_LOOP:
                begin
                    u_checker.expect_frame(data, blen);
                    bus_write(`CAN_ADDR_TX_DATA, data);
                    bus_write(`CAN_ADDR_CMD, 8'h01);
                    exp_irq = 8'h03;
                end
                MODE_EXT:
                begin
                    send_rx_byte(data, blen);
                    exp_irq = 8'h02;
                end
                default:
                begin
                    // Frame time fixed by the bit timing
                    repeat (10 * blen) @(negedge clk);
                    exp_irq = 8'h00;
                end
            endcase

            if (t.mode != MODE_BLOCK)
            begin
                while (irq_on !== 1'b1)
                    @(negedge clk);
                // Transmit side ends after the receive side in loopback
                do
                    bus_read(`CAN_ADDR_STATUS);
                while (lbe_rd_dat !== 8'h00);
            end

            bus_read(`CAN_ADDR_IRQ);
            u_checker.check_read("irq", exp_irq);
            u_checker.check_irq(1'b0);
            bus_read(`CAN_ADDR_IRQ);
            u_checker.check_read("irq_reread", 8'h00);
            bus_read(`CAN_ADDR_STATUS);
            u_checker.check_read("status", 8'h00);
            if (t.mode != MODE_BLOCK)
            begin
                bus_read(`CAN_ADDR_RX_DATA);
                u_checker.check_read("rx_data", data);
            end
            u_checker.end_test();
        end

        u_checker.report_summary();
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

//--- sources.f
+incdir+verilog
verilog/can_lite_pkg.sv
verilog/can_host_regs.sv
verilog/can_bit_timing.sv
verilog/can_bit_shifter.sv
verilog/can_lite_top.sv
verification/can_lite_checker.sv
verification/can_lite_tb.sv

//--- Bender.yml
package:
  name: can_lite

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/can_lite_pkg.sv
      - verilog/can_host_regs.sv
      - verilog/can_bit_timing.sv
      - verilog/can_bit_shifter.sv
      - verilog/can_lite_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verification/can_lite_checker.sv
      - verification/can_lite_tb.sv
